// File: hdl/id_pkg.sv
package id_pkg;

    parameter int XLEN   = 32;
    parameter int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // NOP stays at zero so a cleared bundle is a bubble
    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_AUIPC, ALU_JMP, ALU_BRANCH,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_ZERO = 2'd0,
        SRC_REG  = 2'd1,
        SRC_IMM  = 2'd2,
        SRC_PC   = 2'd3
    } src_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        reg_addr_t  rd;
        logic       we;
        src_sel_e   sel1;
        src_sel_e   sel2;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        logic [2:0] funct3;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
    } decode_t;

    // one later stage's write-back view, is_load only meaningful from EX
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
        logic      is_load;
    } fwd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      we;
        word_t     src1;
        word_t     src2;
    } ex_bundle_t;

endpackage

// File: hdl/inst_decoder.sv
module inst_decoder (
    input  id_pkg::word_t   inst_i,
    output id_pkg::decode_t dec_o
);

    logic [6:0]       funct7;
    logic [2:0]       funct3;
    id_pkg::reg_addr_t rs1;
    id_pkg::reg_addr_t rs2;
    id_pkg::reg_addr_t rd;
    id_pkg::word_t    imm_i;
    id_pkg::word_t    imm_u;
    id_pkg::word_t    imm_j;
    id_pkg::word_t    imm_b;
    id_pkg::word_t    imm_shamt;

    assign funct7 = inst_i[31:25];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign rd     = inst_i[11:7];

    assign imm_i     = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u     = {inst_i[31:12], 12'd0};
    assign imm_j     = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b     = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_shamt = {27'd0, inst_i[24:20]};

    always_comb begin
        // default is a bubble, anything unrecognised falls through as NOP
        dec_o = '0;
        case (id_pkg::opcode_e'(inst_i[6:0]))
            id_pkg::OPC_LUI: begin
                dec_o.alu_op = id_pkg::ALU_LUI;
                dec_o.rd     = rd;
                dec_o.we     = 1'b1;
                dec_o.sel1   = id_pkg::SRC_IMM;
                dec_o.imm    = imm_u;
            end
            id_pkg::OPC_AUIPC: begin
                dec_o.alu_op = id_pkg::ALU_AUIPC;
                dec_o.rd     = rd;
                dec_o.we     = 1'b1;
                dec_o.sel1   = id_pkg::SRC_IMM;
                dec_o.sel2   = id_pkg::SRC_PC;
                dec_o.imm    = imm_u;
            end
            id_pkg::OPC_JAL: begin
                dec_o.alu_op = id_pkg::ALU_JMP;
                dec_o.rd     = rd;
                dec_o.we     = 1'b1;
                dec_o.imm    = imm_j;
                dec_o.is_jal = 1'b1;
            end
            id_pkg::OPC_JALR: begin
                dec_o.alu_op  = id_pkg::ALU_JMP;
                dec_o.rd      = rd;
                dec_o.we      = 1'b1;
                dec_o.sel1    = id_pkg::SRC_REG;
                dec_o.rs1     = rs1;
                dec_o.imm     = imm_i;
                dec_o.is_jalr = 1'b1;
            end
            id_pkg::OPC_BRANCH: begin
                dec_o.alu_op    = id_pkg::ALU_BRANCH;
                dec_o.sel1      = id_pkg::SRC_REG;
                dec_o.sel2      = id_pkg::SRC_REG;
                dec_o.rs1       = rs1;
                dec_o.rs2       = rs2;
                dec_o.imm       = imm_b;
                dec_o.funct3    = funct3;
                dec_o.is_branch = 1'b1;
            end
            id_pkg::OPC_LOAD: begin
                dec_o.rd   = rd;
                dec_o.we   = 1'b1;
                dec_o.sel1 = id_pkg::SRC_REG;
                dec_o.rs1  = rs1;
                dec_o.imm  = imm_i;
                case (funct3)
                    3'b000:  dec_o.alu_op = id_pkg::ALU_LB;
                    3'b001:  dec_o.alu_op = id_pkg::ALU_LH;
                    3'b010:  dec_o.alu_op = id_pkg::ALU_LW;
                    3'b100:  dec_o.alu_op = id_pkg::ALU_LBU;
                    3'b101:  dec_o.alu_op = id_pkg::ALU_LHU;
                    default: dec_o.we     = 1'b0;
                endcase
            end
            id_pkg::OPC_STORE: begin
                dec_o.sel1 = id_pkg::SRC_REG;
                dec_o.sel2 = id_pkg::SRC_REG;
                dec_o.rs1  = rs1;
                dec_o.rs2  = rs2;
                case (funct3)
                    3'b000:  dec_o.alu_op = id_pkg::ALU_SB;
                    3'b001:  dec_o.alu_op = id_pkg::ALU_SH;
                    3'b010:  dec_o.alu_op = id_pkg::ALU_SW;
                    default: dec_o.alu_op = id_pkg::ALU_NOP;
                endcase
            end
            id_pkg::OPC_OP_IMM: begin
                dec_o.rd   = rd;
                dec_o.we   = 1'b1;
                dec_o.sel1 = id_pkg::SRC_REG;
                dec_o.sel2 = id_pkg::SRC_IMM;
                dec_o.rs1  = rs1;
                dec_o.imm  = imm_i;
                case (funct3)
                    3'b000: dec_o.alu_op = id_pkg::ALU_ADD;
                    3'b001: dec_o.alu_op = id_pkg::ALU_SLL;
                    3'b010: dec_o.alu_op = id_pkg::ALU_SLT;
                    3'b011: dec_o.alu_op = id_pkg::ALU_SLTU;
                    3'b100: dec_o.alu_op = id_pkg::ALU_XOR;
                    3'b110: dec_o.alu_op = id_pkg::ALU_OR;
                    3'b111: dec_o.alu_op = id_pkg::ALU_AND;
                    default: begin
                        // srli / srai, funct7 bit 5 picks arithmetic
                        dec_o.alu_op = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                        dec_o.imm    = imm_shamt;
                    end
                endcase
            end
            id_pkg::OPC_OP: begin
                dec_o.rd   = rd;
                dec_o.we   = 1'b1;
                dec_o.sel1 = id_pkg::SRC_REG;
                dec_o.sel2 = id_pkg::SRC_REG;
                dec_o.rs1  = rs1;
                dec_o.rs2  = rs2;
                case (funct3)
                    3'b000:  dec_o.alu_op = funct7[5] ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
                    3'b001:  dec_o.alu_op = id_pkg::ALU_SLL;
                    3'b010:  dec_o.alu_op = id_pkg::ALU_SLT;
                    3'b011:  dec_o.alu_op = id_pkg::ALU_SLTU;
                    3'b100:  dec_o.alu_op = id_pkg::ALU_XOR;
                    3'b101:  dec_o.alu_op = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                    3'b110:  dec_o.alu_op = id_pkg::ALU_OR;
                    default: dec_o.alu_op = id_pkg::ALU_AND;
                endcase
            end
            default: dec_o = '0;
        endcase
    end

endmodule

// File: hdl/operand_select.sv
module operand_select (
    input  id_pkg::src_sel_e  sel_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::word_t     operand_o,
    output logic              load_hazard_o
);

    logic uses_reg;
    logic ex_hit;
    logic mem_hit;

    // x0 is never forwarded
    assign uses_reg = (sel_i == id_pkg::SRC_REG) && (addr_i != '0);
    assign ex_hit   = uses_reg && ex_fwd_i.we && (ex_fwd_i.rd == addr_i);
    assign mem_hit  = uses_reg && mem_fwd_i.we && (mem_fwd_i.rd == addr_i);

    // load data not ready until after MEM
    assign load_hazard_o = ex_hit && ex_fwd_i.is_load;

    always_comb begin
        case (sel_i)
            id_pkg::SRC_REG: begin
                if (ex_hit) begin
                    operand_o = ex_fwd_i.data;
                end else if (mem_hit) begin
                    operand_o = mem_fwd_i.data;
                end else begin
                    operand_o = rf_data_i;
                end
            end
            id_pkg::SRC_IMM: operand_o = imm_i;
            id_pkg::SRC_PC:  operand_o = pc_i;
            default:         operand_o = '0;
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
module branch_unit (
    input  id_pkg::decode_t dec_i,
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   src1_i,
    input  id_pkg::word_t   src2_i,
    input  logic            stall_i,
    output logic            taken_o,
    output id_pkg::word_t   target_o,
    output id_pkg::word_t   link_o
);

    logic          cond;
    logic          is_jump;
    id_pkg::word_t jalr_sum;

    assign is_jump  = dec_i.is_jal | dec_i.is_jalr;
    assign jalr_sum = src1_i + dec_i.imm;

    always_comb begin
        case (dec_i.funct3)
            3'b000:  cond = (src1_i == src2_i);
            3'b001:  cond = (src1_i != src2_i);
            3'b100:  cond = ($signed(src1_i) < $signed(src2_i));
            3'b101:  cond = ($signed(src1_i) >= $signed(src2_i));
            3'b110:  cond = (src1_i < src2_i);
            3'b111:  cond = (src1_i >= src2_i);
            default: cond = 1'b0;
        endcase
    end

    // a stalled instruction must not redirect fetch
    assign taken_o = !stall_i && (is_jump || (dec_i.is_branch && cond));

    always_comb begin
        if (dec_i.is_jalr) begin
            target_o = {jalr_sum[31:1], 1'b0};
        end else if (dec_i.is_jal || dec_i.is_branch) begin
            target_o = pc_i + dec_i.imm;
        end else begin
            target_o = '0;
        end
    end

    assign link_o = is_jump ? pc_i + 32'd4 : '0;

endmodule

// File: hdl/id_ex_reg.sv
module id_ex_reg (
    input  logic               clk,
    input  logic               RST,
    input  id_pkg::decode_t    dec_i,
    input  id_pkg::word_t      src1_i,
    input  id_pkg::word_t      src2_i,
    input  logic               stall_i,
    output id_pkg::ex_bundle_t ex_o
);

    id_pkg::ex_bundle_t next_bundle;

    // jumps keep the selected operands and the ALU forms the link itself
    always_comb begin
        next_bundle.alu_op = dec_i.alu_op;
        next_bundle.rd     = dec_i.rd;
        next_bundle.we     = dec_i.we;
        next_bundle.src1   = src1_i;
        next_bundle.src2   = src2_i;
    end

    // an all-zero bundle is the bubble since ALU_NOP encodes as zero
    always_ff @(posedge clk) begin
        if (RST || stall_i) begin
            ex_o <= '0;
        end else begin
            ex_o <= next_bundle;
        end
    end

endmodule

// File: hdl/id_stage.sv
module id_stage (
    input  logic               clk,
    input  logic               RST,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::word_t      inst_i,
    input  id_pkg::word_t      rs1_data_i,
    input  id_pkg::word_t      rs2_data_i,
    input  id_pkg::fwd_t       ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    output id_pkg::reg_addr_t  rs1_addr_o,
    output id_pkg::reg_addr_t  rs2_addr_o,
    output logic               stall_o,
    output logic               branch_taken_o,
    output id_pkg::word_t      branch_target_o,
    output id_pkg::word_t      link_addr_o,
    output id_pkg::ex_bundle_t ex_o
);

    id_pkg::decode_t dec;
    id_pkg::word_t   src1;
    id_pkg::word_t   src2;
    logic            hazard1;
    logic            hazard2;

    inst_decoder inst_decoder_0 (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;

    operand_select operand_select_1 (
        .sel_i         (dec.sel1),
        .addr_i        (dec.rs1),
        .imm_i         (dec.imm),
        .pc_i          (pc_i),
        .rf_data_i     (rs1_data_i),
        .ex_fwd_i      (ex_fwd_i),
        .mem_fwd_i     (mem_fwd_i),
        .operand_o     (src1),
        .load_hazard_o (hazard1)
    );

    operand_select operand_select_2 (
        .sel_i         (dec.sel2),
        .addr_i        (dec.rs2),
        .imm_i         (dec.imm),
        .pc_i          (pc_i),
        .rf_data_i     (rs2_data_i),
        .ex_fwd_i      (ex_fwd_i),
        .mem_fwd_i     (mem_fwd_i),
        .operand_o     (src2),
        .load_hazard_o (hazard2)
    );

    // load-use on either source holds the stage
    assign stall_o = hazard1 | hazard2;

    branch_unit branch_unit_0 (
        .dec_i    (dec),
        .pc_i     (pc_i),
        .src1_i   (src1),
        .src2_i   (src2),
        .stall_i  (stall_o),
        .taken_o  (branch_taken_o),
        .target_o (branch_target_o),
        .link_o   (link_addr_o)
    );

    id_ex_reg id_ex_reg_0 (
        .clk     (clk),
        .RST     (RST),
        .dec_i   (dec),
        .src1_i  (src1),
        .src2_i  (src2),
        .stall_i (stall_o),
        .ex_o    (ex_o)
    );

endmodule

// File: test/tb_id_stage.sv
module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    // the tests run about 125 cycles so the limit leaves a wide margin
    localparam int TEST_CYCLES = 400;
    localparam int MAX_CYCLES  = 5 * TEST_CYCLES;
    localparam id_pkg::fwd_t NO_FWD = '0;

    logic               clk;
    logic               RST;
    id_pkg::word_t      pc_i;
    id_pkg::word_t      inst_i;
    id_pkg::word_t      rs1_data_i;
    id_pkg::word_t      rs2_data_i;
    id_pkg::fwd_t       ex_fwd_i;
    id_pkg::fwd_t       mem_fwd_i;
    id_pkg::reg_addr_t  rs1_addr_o;
    id_pkg::reg_addr_t  rs2_addr_o;
    logic               stall_o;
    logic               branch_taken_o;
    id_pkg::word_t      branch_target_o;
    id_pkg::word_t      link_addr_o;
    id_pkg::ex_bundle_t ex_o;

    int seed = 1450;
    int cycles = 0;
    int tests = 0;
    int checks = 0;
    int errors = 0;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic id_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    // x1..x31
    function automatic id_pkg::reg_addr_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] % 5'd31) + 5'd1;
    endfunction

    function automatic id_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic id_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic id_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic id_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic id_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic id_pkg::fwd_t mk_fwd(input logic we, input id_pkg::reg_addr_t rd,
            input id_pkg::word_t data, input logic is_load);
        id_pkg::fwd_t f;
        f.we      = we;
        f.rd      = rd;
        f.data    = data;
        f.is_load = is_load;
        return f;
    endfunction

    // rv32i branch conditions by funct3, signed order by flipping both sign bits
    function automatic logic branch_rule(input logic [2:0] f3, input id_pkg::word_t a,
            input id_pkg::word_t b);
        logic eq;
        logic ltu;
        logic lt;
        eq  = (a == b);
        ltu = (a < b);
        lt  = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
        case (f3)
            3'b000:  return eq;
            3'b001:  return !eq;
            3'b100:  return lt;
            3'b101:  return !lt;
            3'b110:  return ltu;
            3'b111:  return !ltu;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ctrl(input id_pkg::alu_op_e op, input id_pkg::reg_addr_t rd,
            input logic we);
        check("ex_o.alu_op", 32'(op), 32'(ex_o.alu_op));
        check("ex_o.rd", 32'(rd), 32'(ex_o.rd));
        check("ex_o.we", 32'(we), 32'(ex_o.we));
    endtask

    task automatic check_ex(input id_pkg::alu_op_e op, input id_pkg::reg_addr_t rd,
            input logic we, input id_pkg::word_t s1, input id_pkg::word_t s2);
        check_ctrl(op, rd, we);
        check("ex_o.src1", s1, ex_o.src1);
        check("ex_o.src2", s2, ex_o.src2);
    endtask

    // inputs change 1 ns after the edge and combinational outputs are read at the falling edge
    task automatic issue(input id_pkg::word_t pc, input id_pkg::word_t inst,
            input id_pkg::word_t d1, input id_pkg::word_t d2,
            input id_pkg::fwd_t exf, input id_pkg::fwd_t memf);
        @(posedge clk);
        #1;
        pc_i       = pc;
        inst_i     = inst;
        rs1_data_i = d1;
        rs2_data_i = d2;
        ex_fwd_i   = exf;
        mem_fwd_i  = memf;
        @(negedge clk);
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("test %-10s %0d errors", name, errors - start);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        // a live add during reset must still leave a bubble
        inst_i     = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, id_pkg::OPC_OP);
        rs1_data_i = rand_word();
        rs2_data_i = rand_word();
        repeat (2) @(posedge clk);
        #1;
        check_ex(id_pkg::ALU_NOP, 5'd0, 1'b0, 32'd0, 32'd0);
        inst_i     = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        repeat (2) @(posedge clk);
        #1;
        RST = 1'b0;
        @(negedge clk);
        check("stall_o", 32'd0, 32'(stall_o));
        check("branch_taken_o", 32'd0, 32'(branch_taken_o));
        next_edge();
        check_ex(id_pkg::ALU_NOP, 5'd0, 1'b0, 32'd0, 32'd0);
        finish_test("reset", start);
    endtask

    task automatic run_op(input logic [2:0] f3, input logic [6:0] f7,
            input id_pkg::alu_op_e op);
        id_pkg::reg_addr_t rs1;
        id_pkg::reg_addr_t rs2;
        id_pkg::reg_addr_t rd;
        id_pkg::word_t     d1;
        id_pkg::word_t     d2;
        rs1 = rand_reg();
        rs2 = rand_reg();
        rd  = rand_reg();
        d1  = rand_word();
        d2  = rand_word();
        issue(rand_word(), enc_r(f7, rs2, rs1, f3, rd, id_pkg::OPC_OP), d1, d2, NO_FWD, NO_FWD);
        check("rs1_addr_o", 32'(rs1), 32'(rs1_addr_o));
        check("rs2_addr_o", 32'(rs2), 32'(rs2_addr_o));
        next_edge();
        check_ex(op, rd, 1'b1, d1, d2);
    endtask

    task automatic run_opimm(input logic [2:0] f3, input logic [6:0] f7,
            input id_pkg::alu_op_e op, input logic shift, input logic zext);
        id_pkg::reg_addr_t rs1;
        id_pkg::reg_addr_t rd;
        id_pkg::word_t     d1;
        id_pkg::word_t     w;
        logic [11:0]       imm;
        id_pkg::word_t     exp2;
        rs1 = rand_reg();
        rd  = rand_reg();
        d1  = rand_word();
        w   = rand_word();
        imm = shift ? {f7, w[4:0]} : w[11:0];
        exp2 = zext ? {27'd0, imm[4:0]} : {{20{imm[11]}}, imm};
        issue(rand_word(), enc_i(imm, rs1, f3, rd, id_pkg::OPC_OP_IMM), d1, 32'd0,
              NO_FWD, NO_FWD);
        next_edge();
        check_ex(op, rd, 1'b1, d1, exp2);
    endtask

    task automatic test_alu_decode();
        int start;
        start = errors;
        run_op(3'b000, 7'h00, id_pkg::ALU_ADD);
        run_op(3'b000, 7'h20, id_pkg::ALU_SUB);
        run_op(3'b001, 7'h00, id_pkg::ALU_SLL);
        run_op(3'b010, 7'h00, id_pkg::ALU_SLT);
        run_op(3'b011, 7'h00, id_pkg::ALU_SLTU);
        run_op(3'b100, 7'h00, id_pkg::ALU_XOR);
        run_op(3'b101, 7'h00, id_pkg::ALU_SRL);
        run_op(3'b101, 7'h20, id_pkg::ALU_SRA);
        run_op(3'b110, 7'h00, id_pkg::ALU_OR);
        run_op(3'b111, 7'h00, id_pkg::ALU_AND);
        run_opimm(3'b000, 7'h00, id_pkg::ALU_ADD, 1'b0, 1'b0);
        run_opimm(3'b010, 7'h00, id_pkg::ALU_SLT, 1'b0, 1'b0);
        run_opimm(3'b011, 7'h00, id_pkg::ALU_SLTU, 1'b0, 1'b0);
        run_opimm(3'b100, 7'h00, id_pkg::ALU_XOR, 1'b0, 1'b0);
        run_opimm(3'b110, 7'h00, id_pkg::ALU_OR, 1'b0, 1'b0);
        run_opimm(3'b111, 7'h00, id_pkg::ALU_AND, 1'b0, 1'b0);
        run_opimm(3'b001, 7'h00, id_pkg::ALU_SLL, 1'b1, 1'b0);
        run_opimm(3'b101, 7'h00, id_pkg::ALU_SRL, 1'b1, 1'b1);
        run_opimm(3'b101, 7'h20, id_pkg::ALU_SRA, 1'b1, 1'b1);
        finish_test("alu_decode", start);
    endtask

    task automatic test_forwarding();
        int            start;
        id_pkg::word_t d1;
        id_pkg::word_t d2;
        id_pkg::word_t a;
        id_pkg::word_t b;
        start = errors;
        d1 = rand_word();
        d2 = rand_word();
        a  = rand_word();
        b  = rand_word();
        // add x5, x3, x4 with both later stages writing x3
        issue(32'h100, enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd5, id_pkg::OPC_OP), d1, d2,
              mk_fwd(1'b1, 5'd3, a, 1'b0), mk_fwd(1'b1, 5'd3, b, 1'b0));
        next_edge();
        check("ex_o.src1", a, ex_o.src1);
        check("ex_o.src2", d2, ex_o.src2);
        issue(32'h104, enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd5, id_pkg::OPC_OP), d1, d2,
              mk_fwd(1'b1, 5'd9, a, 1'b0), mk_fwd(1'b1, 5'd4, b, 1'b0));
        next_edge();
        check("ex_o.src1", d1, ex_o.src1);
        check("ex_o.src2", b, ex_o.src2);
        // x0 as source with writes to x0 in flight
        issue(32'h108, enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd5, id_pkg::OPC_OP), d1, d2,
              mk_fwd(1'b1, 5'd0, a, 1'b0), mk_fwd(1'b1, 5'd0, b, 1'b0));
        next_edge();
        check("ex_o.src1", d1, ex_o.src1);
        check("ex_o.src2", d2, ex_o.src2);
        finish_test("forwarding", start);
    endtask

    task automatic test_load_use();
        int            start;
        id_pkg::word_t d1;
        id_pkg::word_t beq;
        start = errors;
        d1  = rand_word();
        beq = enc_b(13'd16, 5'd7, 5'd6, 3'b000);
        issue(32'h200, beq, d1, d1, mk_fwd(1'b1, 5'd6, rand_word(), 1'b1), NO_FWD);
        check("stall_o", 32'd1, 32'(stall_o));
        check("branch_taken_o", 32'd0, 32'(branch_taken_o));
        next_edge();
        check_ex(id_pkg::ALU_NOP, 5'd0, 1'b0, 32'd0, 32'd0);
        issue(32'h204, enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd5, id_pkg::OPC_OP), d1, d1,
              mk_fwd(1'b1, 5'd7, rand_word(), 1'b1), NO_FWD);
        check("stall_o", 32'd1, 32'(stall_o));
        next_edge();
        check_ex(id_pkg::ALU_NOP, 5'd0, 1'b0, 32'd0, 32'd0);
        issue(32'h208, beq, d1, d1, mk_fwd(1'b1, 5'd12, rand_word(), 1'b1), NO_FWD);
        check("stall_o", 32'd0, 32'(stall_o));
        check("branch_taken_o", 32'd1, 32'(branch_taken_o));
        next_edge();
        check("ex_o.alu_op", 32'(id_pkg::ALU_BRANCH), 32'(ex_o.alu_op));
        finish_test("load_use", start);
    endtask

    task automatic run_branch(input logic [2:0] f3);
        int            i;
        id_pkg::word_t a;
        id_pkg::word_t b;
        id_pkg::word_t w;
        id_pkg::word_t pc;
        logic [12:0]   imm;
        for (i = 0; i < 6; i++) begin
            a   = rand_word();
            b   = rand_word();
            w   = rand_word();
            pc  = rand_word() & 32'hffff_fffc;
            imm = {w[12:1], 1'b0};
            // equal operands, then operands whose signed and unsigned order differ
            if (i == 0) b = a;
            if (i == 1) b = a ^ 32'h8000_0000;
            issue(pc, enc_b(imm, 5'd2, 5'd1, f3), a, b, NO_FWD, NO_FWD);
            check("branch_taken_o", 32'(branch_rule(f3, a, b)), 32'(branch_taken_o));
            check("branch_target_o", pc + {{19{imm[12]}}, imm}, branch_target_o);
            check("link_addr_o", 32'd0, link_addr_o);
        end
    endtask

    task automatic test_branches();
        int                start;
        int                i;
        id_pkg::word_t     w;
        id_pkg::word_t     pc;
        id_pkg::word_t     d1;
        id_pkg::reg_addr_t rs1;
        id_pkg::reg_addr_t rd;
        logic [20:0]       jimm;
        start = errors;
        run_branch(3'b000);
        run_branch(3'b001);
        run_branch(3'b100);
        run_branch(3'b101);
        run_branch(3'b110);
        run_branch(3'b111);
        for (i = 0; i < 4; i++) begin
            w    = rand_word();
            pc   = rand_word() & 32'hffff_fffc;
            d1   = rand_word();
            rs1  = rand_reg();
            rd   = rand_reg();
            jimm = {w[20:1], 1'b0};
            issue(pc, enc_j(jimm, rd), 32'd0, 32'd0, NO_FWD, NO_FWD);
            check("branch_taken_o", 32'd1, 32'(branch_taken_o));
            check("branch_target_o", pc + {{11{jimm[20]}}, jimm}, branch_target_o);
            check("link_addr_o", pc + 32'd4, link_addr_o);
            next_edge();
            check_ctrl(id_pkg::ALU_JMP, rd, 1'b1);
            issue(pc, enc_i(w[11:0], rs1, 3'b000, rd, id_pkg::OPC_JALR), d1, 32'd0,
                  NO_FWD, NO_FWD);
            check("branch_taken_o", 32'd1, 32'(branch_taken_o));
            check("branch_target_o", (d1 + {{20{w[11]}}, w[11:0]}) & 32'hffff_fffe,
                  branch_target_o);
            check("link_addr_o", pc + 32'd4, link_addr_o);
            check("rs1_addr_o", 32'(rs1), 32'(rs1_addr_o));
        end
        finish_test("branches", start);
    endtask

    task automatic run_mem(input logic is_store, input logic [2:0] f3,
            input id_pkg::alu_op_e op);
        id_pkg::reg_addr_t rd;
        id_pkg::word_t     w;
        rd = rand_reg();
        w  = rand_word();
        if (is_store) begin
            issue(32'h300, enc_s(w[11:0], rand_reg(), rand_reg(), f3), w, w, NO_FWD, NO_FWD);
            next_edge();
            check("ex_o.alu_op", 32'(op), 32'(ex_o.alu_op));
            check("ex_o.we", 32'd0, 32'(ex_o.we));
        end else begin
            issue(32'h300, enc_i(w[11:0], rand_reg(), f3, rd, id_pkg::OPC_LOAD), w, w,
                  NO_FWD, NO_FWD);
            next_edge();
            check_ctrl(op, rd, 1'b1);
            check("ex_o.src1", w, ex_o.src1);
        end
    endtask

    task automatic test_upper_mem();
        int                start;
        id_pkg::word_t     w;
        id_pkg::word_t     pc;
        id_pkg::reg_addr_t rd;
        start = errors;
        w  = rand_word();
        pc = rand_word() & 32'hffff_fffc;
        rd = rand_reg();
        issue(pc, {w[31:12], rd, 7'(id_pkg::OPC_LUI)}, 32'd0, 32'd0, NO_FWD, NO_FWD);
        next_edge();
        check_ctrl(id_pkg::ALU_LUI, rd, 1'b1);
        check("ex_o.src1", {w[31:12], 12'd0}, ex_o.src1);
        issue(pc, {w[31:12], rd, 7'(id_pkg::OPC_AUIPC)}, 32'd0, 32'd0, NO_FWD, NO_FWD);
        next_edge();
        check_ex(id_pkg::ALU_AUIPC, rd, 1'b1, {w[31:12], 12'd0}, pc);
        run_mem(1'b0, 3'b000, id_pkg::ALU_LB);
        run_mem(1'b0, 3'b001, id_pkg::ALU_LH);
        run_mem(1'b0, 3'b010, id_pkg::ALU_LW);
        run_mem(1'b0, 3'b100, id_pkg::ALU_LBU);
        run_mem(1'b0, 3'b101, id_pkg::ALU_LHU);
        run_mem(1'b1, 3'b000, id_pkg::ALU_SB);
        run_mem(1'b1, 3'b001, id_pkg::ALU_SH);
        run_mem(1'b1, 3'b010, id_pkg::ALU_SW);
        finish_test("upper_mem", start);
    endtask

    initial begin
        RST        = 1'b1;
        pc_i       = '0;
        inst_i     = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        ex_fwd_i   = '0;
        mem_fwd_i  = '0;
        test_reset();
        test_alu_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_upper_mem();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_select.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
test/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat vlog.f)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator and run it, fails unless the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

$(SIM): vlog.f $(SOURCES)
	$(VERILATOR) $(FLAGS) -f vlog.f --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
